//--- hdl/vectorAluPkg.sv
package vectorAluPkg;

    localparam int dataWidth = 64;              // full register width
    localparam int byteLanes = dataWidth / 8;   // 8 byte lanes
    localparam int mulWidth  = dataWidth / 2;   // even or odd half fed to the multipliers

    // bit 0 is the msb, lane 0 the most significant lane
    typedef logic [0:dataWidth-1] vecWordT;
    typedef logic [0:mulWidth-1]  mulHalfT;

    // element width field
    typedef enum logic [0:1] {
        widthByte  = 2'b00,
        widthHalf  = 2'b01,
        widthWord  = 2'b10,
        widthDword = 2'b11
    } elemWidthT;

    // function codes, values as in the vector ISA
    typedef enum logic [0:5] {
        opAnd     = 6'd1,
        opOr      = 6'd2,
        opXor     = 6'd3,
        opNot     = 6'd4,
        opMov     = 6'd5,
        opAdd     = 6'd6,
        opSub     = 6'd7,
        opMulEven = 6'd8,
        opMulOdd  = 6'd9,
        opSll     = 6'd10,
        opSrl     = 6'd11,
        opSra     = 6'd12,
        opRotHalf = 6'd13,   // 14, 15 were div/mod
        opSqEven  = 6'd16,
        opSqOdd   = 6'd17
    } aluOpT;

    // which execute unit owns the result
    typedef enum logic [0:1] {
        unitNone = 2'd0,     // result forced to zero
        unitLane = 2'd1,     // logic, add/sub, shift, rotate
        unitMult = 2'd2      // even/odd multiply and square
    } aluUnitT;

endpackage

//--- hdl/operandStage.sv
`timescale 1ns/1ps

module operandStage
    import vectorAluPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      opValid,
    input  vecWordT   opA,
    input  vecWordT   opB,
    input  aluOpT     op,
    input  elemWidthT width,
    output logic      s1Valid,
    output aluUnitT   s1Unit,
    output aluOpT     s1Op,
    output elemWidthT s1Width,
    output vecWordT   s1A,
    output vecWordT   s1B,
    output mulHalfT   s1MulA,
    output mulHalfT   s1MulB
);

    aluUnitT unitNext;
    logic    oddSel;     // odd lanes instead of even
    logic    squareSel;  // B side taken from A

    // packs every other element of v, even (0, 2, ..) or odd (1, 3, ..)
    function automatic mulHalfT gatherLanes(input vecWordT v, input elemWidthT w,
                                            input logic odd);
        mulHalfT r;
        r = '0;
        case (w)
            widthByte: for (int k = 0; k < 4; k++) r[k*8 +: 8] = v[(2*k + odd)*8 +: 8];
            widthHalf: for (int k = 0; k < 2; k++) r[k*16 +: 16] = v[(2*k + odd)*16 +: 16];
            widthWord: r = v[odd*32 +: 32];
            default:   r = '0;  // no dword multiplier
        endcase
        return r;
    endfunction

    assign oddSel    = (op == opMulOdd) || (op == opSqOdd);
    assign squareSel = (op == opSqEven) || (op == opSqOdd);

    // unit decode, the only place the opcode picks a unit
    always_comb begin
        case (op)
            opAnd, opOr, opXor, opNot, opMov,
            opAdd, opSub, opSll, opSrl, opSra, opRotHalf: unitNext = unitLane;
            opMulEven, opMulOdd, opSqEven, opSqOdd:
                unitNext = (width == widthDword) ? unitNone : unitMult;
            default: unitNext = unitNone;  // undefined codes read as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s1Unit  <= unitNone;
        end else begin
            s1Valid <= opValid;
            s1Unit  <= unitNext;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        s1Op    <= op;
        s1Width <= width;
        s1A     <= opA;
        s1B     <= opB;
        s1MulA  <= gatherLanes(opA, width, oddSel);
        s1MulB  <= gatherLanes(squareSel ? opA : opB, width, oddSel); // square uses A twice
    end

endmodule

//--- hdl/partitionedAlu.sv
`timescale 1ns/1ps

module partitionedAlu
    import vectorAluPkg::*;
(
    input  vecWordT   a,
    input  vecWordT   b,
    input  aluOpT     op,
    input  elemWidthT width,
    output vecWordT   result
);

    logic             isSub;
    vecWordT          bEff;      // b or ~b for subtract
    vecWordT          sumDiff;
    logic [0:byteLanes-1] carry; // carry[i] is the carry out of byte i
    vecWordT [0:3]    shlRes;    // one entry per element width
    vecWordT [0:3]    srlRes;
    vecWordT [0:3]    sraRes;
    vecWordT [0:3]    rotRes;

    // true when byte idx is the lsb byte of its element
    function automatic logic laneLsb(input int idx, input elemWidthT w);
        return ((idx + 1) % (1 << w)) == 0;
    endfunction

    assign isSub = (op == opSub);
    assign bEff  = isSub ? ~b : b;

    // byte carry chain, cut at every element edge
    for (genvar i = 0; i < byteLanes; i++) begin : gByte
        logic       cin;
        logic [0:8] sum9;  // sum9[0] is the carry out

        if (i == byteLanes - 1) begin : gLast
            assign cin = isSub;  // last byte is the lsb of every width
        end else begin : gInner
            assign cin = laneLsb(i, width) ? isSub : carry[i+1]; // +1 of two's complement at lsb
        end
        assign sum9 = {1'b0, a[i*8 +: 8]} + {1'b0, bEff[i*8 +: 8]} + cin;
        assign sumDiff[i*8 +: 8] = sum9[1:8];
        assign carry[i] = sum9[0];
    end

    // shifts and half rotate, one bank per width
    for (genvar w = 0; w < 4; w++) begin : gWidth
        for (genvar e = 0; e < (byteLanes >> w); e++) begin : gLane
            logic [0:(8<<w)-1] aLane;
            logic [0:2+w]      sh;   // low log2(lane) bits of the b lane

            assign aLane = a[e*(8<<w) +: (8<<w)];
            assign sh    = b[e*(8<<w) + (8<<w) - (3+w) +: (3+w)];

            assign shlRes[w][e*(8<<w) +: (8<<w)] = aLane << sh;
            assign srlRes[w][e*(8<<w) +: (8<<w)] = aLane >> sh;
            assign sraRes[w][e*(8<<w) +: (8<<w)] = $signed(aLane) >>> sh; // lane's own sign
            // swap upper and lower half
            assign rotRes[w][e*(8<<w) +: (8<<w)] = {aLane[(4<<w) +: (4<<w)],
                                                    aLane[0 +: (4<<w)]};
        end
    end

    always_comb begin
        case (op)
            opAnd:        result = a & b;
            opOr:         result = a | b;
            opXor:        result = a ^ b;
            opNot:        result = ~a;
            opMov:        result = a;
            opAdd, opSub: result = sumDiff;
            opSll:        result = shlRes[width];
            opSrl:        result = srlRes[width];
            opSra:        result = sraRes[width];
            opRotHalf:    result = rotRes[width];
            default:      result = '0;  // multiplier codes never use this unit
        endcase
    end

endmodule

//--- hdl/evenOddMultiplier.sv
`timescale 1ns/1ps

module evenOddMultiplier
    import vectorAluPkg::*;
(
    input  mulHalfT   mulA,
    input  mulHalfT   mulB,
    input  elemWidthT width,
    output vecWordT   product
);

    vecWordT prodByte;   // four 8x8 products
    vecWordT prodHalf;   // two 16x16 products
    vecWordT prodWord;   // one 32x32 product

    // 8x8 bank, product k fills bytes 2k and 2k+1
    for (genvar k = 0; k < 4; k++) begin : gByteMul
        assign prodByte[k*16 +: 16] = 16'(mulA[k*8 +: 8]) * 16'(mulB[k*8 +: 8]);
    end

    // 16x16 bank
    for (genvar k = 0; k < 2; k++) begin : gHalfMul
        assign prodHalf[k*32 +: 32] = 32'(mulA[k*16 +: 16]) * 32'(mulB[k*16 +: 16]);
    end

    // single 32x32, unsigned
    assign prodWord = 64'(mulA) * 64'(mulB);

    always_comb begin
        case (width)
            widthByte: product = prodByte;
            widthHalf: product = prodHalf;
            widthWord: product = prodWord;
            default:   product = '0;  // no dword multiply
        endcase
    end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage
    import vectorAluPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      s1Valid,
    input  aluUnitT   s1Unit,
    input  aluOpT     s1Op,
    input  elemWidthT s1Width,
    input  vecWordT   s1A,
    input  vecWordT   s1B,
    input  mulHalfT   s1MulA,
    input  mulHalfT   s1MulB,
    output logic      resValid,
    output vecWordT   rD
);

    vecWordT laneRes;
    vecWordT prodRes;
    vecWordT selRes;

    partitionedAlu uLaneAlu (
        .a      (s1A),
        .b      (s1B),
        .op     (s1Op),
        .width  (s1Width),
        .result (laneRes)
    );

    evenOddMultiplier uMult (
        .mulA    (s1MulA),
        .mulB    (s1MulB),
        .width   (s1Width),
        .product (prodRes)
    );

    // unit already decoded in stage 1
    always_comb begin
        case (s1Unit)
            unitLane: selRes = laneRes;
            unitMult: selRes = prodRes;
            default:  selRes = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            rD       <= '0;
        end else begin
            resValid <= s1Valid;
            rD       <= selRes;  // follows pipeline even when idle
        end
    end

endmodule

//--- hdl/vectorAlu.sv
`timescale 1ns/1ps

module vectorAlu
    import vectorAluPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      opValid,
    input  vecWordT   opA,
    input  vecWordT   opB,
    input  aluOpT     op,
    input  elemWidthT width,
    output logic      resValid,
    output vecWordT   rD
);

    // stage 1 to stage 2
    logic      s1Valid;
    aluUnitT   s1Unit;
    aluOpT     s1Op;
    elemWidthT s1Width;
    vecWordT   s1A;
    vecWordT   s1B;
    mulHalfT   s1MulA;    // gathered even/odd lanes
    mulHalfT   s1MulB;

    operandStage uOperand (
        .clk     (clk),
        .rst     (rst),
        .opValid (opValid),
        .opA     (opA),
        .opB     (opB),
        .op      (op),
        .width   (width),
        .s1Valid (s1Valid),
        .s1Unit  (s1Unit),
        .s1Op    (s1Op),
        .s1Width (s1Width),
        .s1A     (s1A),
        .s1B     (s1B),
        .s1MulA  (s1MulA),
        .s1MulB  (s1MulB)
    );

    executeStage uExecute (
        .clk      (clk),
        .rst      (rst),
        .s1Valid  (s1Valid),
        .s1Unit   (s1Unit),
        .s1Op     (s1Op),
        .s1Width  (s1Width),
        .s1A      (s1A),
        .s1B      (s1B),
        .s1MulA   (s1MulA),
        .s1MulB   (s1MulB),
        .resValid (resValid),
        .rD       (rD)       // two cycles after opValid
    );

endmodule

//--- tests/vectorAlu_properties.sv
`timescale 1ns/1ps

module vectorAluProperties
    import vectorAluPkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    opValid,
    input logic    resValid,
    input vecWordT rD
);

    int propFails = 0;  // failures seen by the testbench at the end

    // sync reset clears the output registers at the next edge
    resetClears: assert property (@(posedge clk) rst |=> !resValid && rD == '0)
        else begin
            $error("resValid or rD not cleared by reset");
            propFails++;
        end

    // first edge out of reset still sees the flushed stage 1
    resetFlushed: assert property (@(posedge clk) rst ##1 !rst |=> !resValid && rD == '0)
        else begin
            $error("resValid or rD nonzero in the first cycle after reset");
            propFails++;
        end

    latencyTwo: assert property (@(posedge clk)
            !$past(rst, 1) && !$past(rst, 2) |-> resValid == $past(opValid, 2))
        else begin
            $error("resValid does not follow opValid by two cycles");
            propFails++;
        end

    rdKnown: assert property (@(posedge clk) resValid |-> !$isunknown(rD))
        else begin
            $error("rD has unknown bits while resValid is high");
            propFails++;
        end

endmodule

bind vectorAlu vectorAluProperties uProps (
    .clk      (clk),
    .rst      (rst),
    .opValid  (opValid),
    .resValid (resValid),
    .rD       (rD)
);

//--- tests/vectorAluTb.sv
`timescale 1ns/1ps

module vectorAluTb
    import vectorAluPkg::*;
();

    localparam int cycleLimit = 3000;  // ~1000 ops plus gaps and drains

    logic        clk = 1'b0;
    logic        rst;
    logic        opValid;
    vecWordT     opA;
    vecWordT     opB;
    aluOpT       op;
    elemWidthT   width;
    logic        resValid;
    vecWordT     rD;

    logic [63:0] rngState = 64'd22589;
    logic [63:0] expQ[$];      // expected rD, oldest first
    int          tagQ[$];      // edge each op was driven on
    int          cycleCount = 0;
    int          errorCount = 0;
    int          testErrStart = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    logic [63:0] expVal;
    int          issueTag;
    aluOpT       opList[15] = '{opAnd, opOr, opXor, opNot, opMov, opAdd, opSub, opMulEven,
                                opMulOdd, opSll, opSrl, opSra, opRotHalf, opSqEven, opSqOdd};

    vectorAlu DUT (.clk(clk), .rst(rst), .opValid(opValid), .opA(opA), .opB(opB), .op(op),
                   .width(width), .resValid(resValid), .rD(rD));

    always #2 clk = ~clk;
    always @(posedge clk) cycleCount <= cycleCount + 1;

    function automatic logic [63:0] xorshift64(input logic [63:0] v);
        v ^= v << 13;
        v ^= v >> 7;
        v ^= v << 17;
        return v;
    endfunction

    function logic [63:0] nextRand();
        rngState = xorshift64(rngState);
        return rngState;
    endfunction

    // lane idx of length len, lane 0 at the top
    function automatic logic [63:0] laneOf(input logic [63:0] v, input int idx, input int len);
        logic [63:0] mask;
        mask = (len == 64) ? '1 : (64'd1 << len) - 1;
        return (v >> (64 - (idx + 1) * len)) & mask;
    endfunction

    // pat repeated in every lane of width w
    function automatic logic [63:0] perLane(input logic [63:0] pat, input elemWidthT w);
        logic [63:0] acc;
        acc = '0;
        for (int e = 0; e < (8 >> w); e++) acc |= pat << (e * (8 << w));
        return acc;
    endfunction

    function automatic logic [63:0] expectedResult(input logic [63:0] a, input logic [63:0] b,
                                                   input aluOpT code, input elemWidthT w);
        int          len;
        int          s;
        logic [63:0] mask, x, y, r, acc;
        len  = 8 << w;
        mask = (len == 64) ? '1 : (64'd1 << len) - 1;
        acc  = '0;
        case (code)
            opAnd: return a & b;
            opOr:  return a | b;
            opXor: return a ^ b;
            opNot: return ~a;
            opMov: return a;
            opMulEven, opMulOdd, opSqEven, opSqOdd: begin
                if (w == widthDword) return '0;  // no dword product
                for (int k = 0; k < 32 / len; k++) begin
                    s = 2 * k + ((code == opMulOdd || code == opSqOdd) ? 1 : 0);
                    x = laneOf(a, s, len);
                    y = laneOf((code == opSqEven || code == opSqOdd) ? a : b, s, len);
                    acc |= (x * y) << (64 - (k + 1) * 2 * len);  // double-width lane k
                end
                return acc;
            end
            opAdd, opSub, opSll, opSrl, opSra, opRotHalf: begin
                for (int e = 0; e < 64 / len; e++) begin
                    x = laneOf(a, e, len);
                    y = laneOf(b, e, len);
                    s = int'(y & (len - 1));   // low log2(len) bits of own b lane
                    case (code)
                        opAdd:   r = x + y;
                        opSub:   r = x - y;
                        opSll:   r = x << s;
                        opSrl:   r = x >> s;
                        opSra:   r = (x >> s) | (x[len-1] ? mask & ~(mask >> s) : '0);
                        default: r = (x >> (len / 2)) | (x << (len / 2));  // half swap
                    endcase
                    acc |= (r & mask) << (64 - (e + 1) * len);
                end
                return acc;
            end
            default: return '0;
        endcase
    endfunction

    task automatic issueOp(input logic [63:0] a, input logic [63:0] b, input aluOpT code,
                           input elemWidthT w);
        @(posedge clk);
        opValid <= 1'b1;
        opA     <= a;
        opB     <= b;
        op      <= code;
        width   <= w;
        expQ.push_back(expectedResult(a, b, code, w));
        tagQ.push_back(cycleCount + 1);  // number of the edge just taken
    endtask

    task automatic idleCycle();
        @(posedge clk);
        opValid <= 1'b0;
    endtask

    task automatic checkIdleZero();
        @(negedge clk);
        assert (resValid === 1'b0 && rD === '0)
            else begin
                $display("ERR %0t resValid/rD expected 0/0 got %b/%h", $time, resValid, rD);
                errorCount++;
            end
    endtask

    task automatic endTest(input string name);
        idleCycle();
        while (expQ.size() != 0) idleCycle();  // watchdog covers a lost result
        if (errorCount == testErrStart)
            testsPassed++;
        else
            testsFailed++;
        $display("test %s: %s, %0d errors", name,
                 (errorCount == testErrStart) ? "ok" : "failing", errorCount - testErrStart);
        testErrStart = errorCount;
    endtask

    // results checked mid-cycle, well clear of the edge
    always @(negedge clk) begin
        if (resValid) begin
            if (expQ.size() == 0) begin
                $display("resValid high at %0t with no operation outstanding", $time);
                errorCount++;
            end else begin
                expVal   = expQ.pop_front();
                issueTag = tagQ.pop_front();
                assert (rD === expVal)
                    else begin
                        $display("ERR %0t rD expected %h got %h", $time, expVal, rD);
                        errorCount++;
                    end
                assert (cycleCount == issueTag + 2)
                    else begin
                        $display("result at %0t came %0d cycles after its issue instead of 2",
                                 $time, cycleCount - issueTag);
                        errorCount++;
                    end
            end
        end
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("timeout after %0d cycles, %0d results outstanding", cycleCount, expQ.size());
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        opValid = 1'b1;   // live op during reset, stage 1 must drop it
        opA     = '1;
        opB     = '0;
        op      = opMov;
        width   = widthByte;

        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2) begin
                rst     <= 1'b0;
                opValid <= 1'b0;
                opA     <= '0;     // zero operands keep idle rD at zero
                op      <= opAnd;
            end
            checkIdleZero();
        end
        repeat (3) checkIdleZero();
        endTest("reset state");

        for (int i = 0; i < 200; i++)
            issueOp(nextRand(), nextRand(), opList[i % 5], elemWidthT'(i % 4));
        endTest("logic group");

        for (int w = 0; w < 4; w++) begin
            issueOp('1, perLane(64'd1, elemWidthT'(w)), opAdd, elemWidthT'(w)); // all lanes wrap
            issueOp('0, perLane(64'd1, elemWidthT'(w)), opSub, elemWidthT'(w)); // all lanes borrow
            for (int i = 0; i < 40; i++)
                issueOp(nextRand(), nextRand(), i[0] ? opSub : opAdd, elemWidthT'(w));
        end
        endTest("lane add/sub");

        // every other sra gets negative lanes
        for (int w = 0; w < 4; w++)
            for (int i = 0; i < 48; i++)
                issueOp(nextRand() | (i[2] ? perLane(64'd1 << ((8 << w) - 1), elemWidthT'(w)) : '0),
                        nextRand(), opList[9 + i % 4], elemWidthT'(w));
        endTest("shift/rotate");

        for (int w = 0; w < 3; w++)
            for (int i = 0; i < 48; i++)
                issueOp(i < 4 ? '1 : nextRand(), i < 4 ? '1 : nextRand(),
                        opList[(i % 4 < 2) ? 7 + i % 4 : 11 + i % 4], elemWidthT'(w));
        for (int i = 0; i < 4; i++)
            issueOp(nextRand(), nextRand(), opList[(i < 2) ? 7 + i : 11 + i], widthDword);
        issueOp(nextRand(), nextRand(), aluOpT'(6'd14), widthByte);
        issueOp(nextRand(), nextRand(), aluOpT'(6'd0), widthWord);
        issueOp(nextRand(), nextRand(), aluOpT'(6'd63), widthHalf);
        endTest("multiply/square");

        for (int i = 0; i < 300; i++) begin
            if (nextRand() % 4 == 0)
                idleCycle();
            issueOp(nextRand(), nextRand(),
                    (nextRand() % 16 == 0) ? aluOpT'(6'd15) : opList[nextRand() % 15],
                    elemWidthT'(nextRand() % 4));
        end
        endTest("mixed issue");

        $display("tests passed %0d, failed %0d, property failures %0d",
                 testsPassed, testsFailed, DUT.uProps.propFails);
        if (testsFailed == 0 && DUT.uProps.propFails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- src.f
hdl/vectorAluPkg.sv
hdl/operandStage.sv
hdl/partitionedAlu.sv
hdl/evenOddMultiplier.sv
hdl/executeStage.sv
hdl/vectorAlu.sv
tests/vectorAlu_properties.sv
tests/vectorAluTb.sv

//--- Bender.yml
package:
  name: vectorAlu

sources:
  - files:
      - hdl/vectorAluPkg.sv
      - hdl/operandStage.sv
      - hdl/partitionedAlu.sv
      - hdl/evenOddMultiplier.sv
      - hdl/executeStage.sv
      - hdl/vectorAlu.sv
  - target: test
    files:
      - tests/vectorAlu_properties.sv
      - tests/vectorAluTb.sv
